// File: vlog.f
+incdir+.
route_dir_pkg.sv
mesh_coord_pkg.sv
next_hop_xy_route.sv
id_table_route.sv
route_merge.sv
lookahead_route_stage.sv
tb_lookahead_route.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the look-ahead routing testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module tb_lookahead_route \
  -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

if [ ! -x ./obj_dir/Vtb_lookahead_route ]; then
  echo "simulation binary was not produced"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_lookahead_route 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi

echo "pass message not found in the simulation output"
exit 1

// File: tb_lookahead_route.sv
/*
 * Testbench for the look-ahead routing stage:
 * stimulus table of table commands and head flits, applied one row per
 * cycle, a reference model with its own copy of the id table, and
 * random destinations from a Galois LFSR
 */

`timescale 1ns/1ps

`include "noc_macros.svh"

module tb_lookahead_route
  import route_dir_pkg::*;
  import mesh_coord_pkg::*;
();

  localparam int ResetCycles = 10;
  localparam int RandRows    = 32;
  localparam int Margin      = 20;

  typedef struct packed {
    logic [1:0]             cmd;
    rule_idx_t              idx;
    node_id_t               lo;
    node_id_t               hi;
    logic [`NOC_DIR_W-1:0]  tdir;
    logic                   valid;
    x_coord_t               cur_x;
    y_coord_t               cur_y;
    x_coord_t               dst_x;
    y_coord_t               dst_y;
    port_id_t               port;
    logic [`NOC_DIR_W-1:0]  la_dir;
  } stim_row_t;

  typedef struct packed {
    logic                   valid;
    x_coord_t               dst_x;
    y_coord_t               dst_y;
    port_id_t               port;
    logic [`NOC_DIR_W-1:0]  route;
  } out_vec_t;

  logic                   clk;
  logic                   reset;
  x_coord_t               cur_x;
  y_coord_t               cur_y;
  logic                   in_valid;
  x_coord_t               in_dst_x;
  y_coord_t               in_dst_y;
  port_id_t               in_dst_port;
  logic [`NOC_DIR_W-1:0]  in_la_dir;
  table_cmd_e             tbl_cmd;
  rule_idx_t              tbl_idx;
  node_id_t               tbl_lo;
  node_id_t               tbl_hi;
  route_dir_e             tbl_dir;
  logic                   out_valid;
  x_coord_t               out_dst_x;
  y_coord_t               out_dst_y;
  port_id_t               out_dst_port;
  logic [`NOC_DIR_W-1:0]  out_la_route;

  stim_row_t rows[$];
  stim_row_t pend;
  out_vec_t  exp_q[$];
  out_vec_t  m_out;
  x_coord_t  here_x;
  y_coord_t  here_y;
  logic [31:0] lfsr;
  int        cycle_cnt = 0;
  int        cycle_limit = 0;

  // reference copy of the rule table
  logic                  m_valid [`NOC_TABLE_DEPTH];
  node_id_t              m_lo    [`NOC_TABLE_DEPTH];
  node_id_t              m_hi    [`NOC_TABLE_DEPTH];
  logic [`NOC_DIR_W-1:0] m_dir   [`NOC_TABLE_DEPTH];

  lookahead_route_stage uut (
    .clk_i          (clk),
    .reset_i        (reset),
    .cur_x_i        (cur_x),
    .cur_y_i        (cur_y),
    .in_valid_i     (in_valid),
    .in_dst_x_i     (in_dst_x),
    .in_dst_y_i     (in_dst_y),
    .in_dst_port_i  (in_dst_port),
    .in_la_dir_i    (in_la_dir),
    .tbl_cmd_i      (tbl_cmd),
    .tbl_idx_i      (tbl_idx),
    .tbl_lo_i       (tbl_lo),
    .tbl_hi_i       (tbl_hi),
    .tbl_dir_i      (tbl_dir),
    .out_valid_o    (out_valid),
    .out_dst_x_o    (out_dst_x),
    .out_dst_y_o    (out_dst_y),
    .out_dst_port_o (out_dst_port),
    .out_la_route_o (out_la_route)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, act, exp);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // right-shifting Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // route expected from the next hop, the rule table and the eject offset
  function automatic logic [`NOC_DIR_W-1:0] expected_route(input stim_row_t r);
    x_coord_t              nx;
    y_coord_t              ny;
    node_id_t              id;
    logic [`NOC_DIR_W-1:0] dir;
    logic                  found;
    nx = r.cur_x;
    ny = r.cur_y;
    if (r.la_dir == dir_north) begin
      ny = r.cur_y + 3'd1;
    end else if (r.la_dir == dir_east) begin
      nx = r.cur_x + 3'd1;
    end else if (r.la_dir == dir_south) begin
      ny = r.cur_y - 3'd1;
    end else if (r.la_dir == dir_west) begin
      nx = r.cur_x - 3'd1;
    end
    if (r.dst_x > nx) begin
      dir = dir_east;
    end else if (r.dst_x < nx) begin
      dir = dir_west;
    end else if (r.dst_y > ny) begin
      dir = dir_north;
    end else if (r.dst_y < ny) begin
      dir = dir_south;
    end else begin
      dir = dir_eject;
    end
    id    = {r.dst_x, r.dst_y};
    found = 1'b0;
    for (int i = 0; i < `NOC_TABLE_DEPTH; i++) begin
      if (!found && m_valid[i] && (id >= m_lo[i]) && (id <= m_hi[i])) begin
        found = 1'b1;
        dir   = m_dir[i];
      end
    end
    if (dir >= dir_eject) begin
      dir = dir + 3'(r.port);
    end
    return dir;
  endfunction

  // expected outputs of one row, then the table command of that row
  task automatic model_step(input stim_row_t r);
    out_vec_t e;
    e       = m_out;
    e.valid = r.valid;
    if (r.valid) begin
      e.dst_x = r.dst_x;
      e.dst_y = r.dst_y;
      e.port  = r.port;
      e.route = expected_route(r);
    end
    m_out = e;
    exp_q.push_back(e);
    if (r.cmd == cmd_write_rule) begin
      m_valid[r.idx] = 1'b1;
      m_lo[r.idx]    = r.lo;
      m_hi[r.idx]    = r.hi;
      m_dir[r.idx]   = r.tdir;
    end else if (r.cmd == cmd_clear_rule) begin
      m_valid[r.idx] = 1'b0;
    end
  endtask

  task automatic compare_outputs();
    out_vec_t e;
    e = exp_q.pop_front();
    check_val("out_valid_o", 32'(out_valid), 32'(e.valid));
    check_val("out_dst_x_o", 32'(out_dst_x), 32'(e.dst_x));
    check_val("out_dst_y_o", 32'(out_dst_y), 32'(e.dst_y));
    check_val("out_dst_port_o", 32'(out_dst_port), 32'(e.port));
    check_val("out_la_route_o", 32'(out_la_route), 32'(e.route));
  endtask

  task automatic apply_row(input stim_row_t r);
    cur_x       <= r.cur_x;
    cur_y       <= r.cur_y;
    in_valid    <= r.valid;
    in_dst_x    <= r.dst_x;
    in_dst_y    <= r.dst_y;
    in_dst_port <= r.port;
    in_la_dir   <= r.la_dir;
    tbl_cmd     <= table_cmd_e'(r.cmd);
    tbl_idx     <= r.idx;
    tbl_lo      <= r.lo;
    tbl_hi      <= r.hi;
    tbl_dir     <= route_dir_e'(r.tdir);
  endtask

  // a table command rides along with the next row that is added
  task automatic set_table_cmd(input table_cmd_e cmd, input rule_idx_t idx,
                               input node_id_t lo, input node_id_t hi, input route_dir_e dir);
    pend.cmd  = cmd;
    pend.idx  = idx;
    pend.lo   = lo;
    pend.hi   = hi;
    pend.tdir = dir;
  endtask

  task automatic push_row(input logic valid, input x_coord_t dx, input y_coord_t dy,
                          input port_id_t port, input logic [`NOC_DIR_W-1:0] la);
    stim_row_t r;
    r        = pend;
    r.valid  = valid;
    r.cur_x  = here_x;
    r.cur_y  = here_y;
    r.dst_x  = dx;
    r.dst_y  = dy;
    r.port   = port;
    r.la_dir = la;
    rows.push_back(r);
    pend = '0;
  endtask

  task automatic add_flit(input x_coord_t dx, input y_coord_t dy, input port_id_t port,
                          input logic [`NOC_DIR_W-1:0] la);
    push_row(1'b1, dx, dy, port, la);
  endtask

  task automatic add_idle();
    push_row(1'b0, 3'd0, 3'd0, 2'd0, dir_north);
  endtask

  task automatic build_stimulus();
    logic [7:0] v;
    logic       vld;
    x_coord_t   dx;
    y_coord_t   dy;
    port_id_t   port;
    pend   = '0;
    here_x = 3'd3;
    here_y = 3'd3;
    // XY at the next hop, two routes per direction of arrival
    add_flit(3'd5, 3'd3, 2'd0, dir_east);
    add_flit(3'd4, 3'd1, 2'd1, dir_east);
    add_flit(3'd3, 3'd6, 2'd2, dir_north);
    add_flit(3'd1, 3'd5, 2'd3, dir_north);
    add_flit(3'd6, 3'd0, 2'd0, dir_south);
    add_flit(3'd3, 3'd0, 2'd1, dir_south);
    add_flit(3'd0, 3'd3, 2'd2, dir_west);
    add_flit(3'd2, 3'd7, 2'd3, dir_west);
    add_flit(3'd3, 3'd5, 2'd0, dir_eject);
    add_idle();
    add_idle();
    // eject at the next hop on each local port
    for (int p = 0; p < 4; p++) begin
      add_flit(3'd4, 3'd3, 2'(p), dir_east);
    end
    add_flit(3'd3, 3'd3, 2'd2, dir_eject);
    add_idle();
    // corner router, the next hop wraps in 3 bits
    here_x = 3'd0;
    here_y = 3'd0;
    add_flit(3'd7, 3'd0, 2'd1, dir_west);
    add_flit(3'd0, 3'd7, 2'd0, dir_south);
    here_x = 3'd3;
    here_y = 3'd3;
    // table override, a flit in the write cycle still sees the old table
    set_table_cmd(cmd_write_rule, 2'd1, {3'd5, 3'd0}, {3'd5, 3'd7}, dir_west);
    add_flit(3'd5, 3'd2, 2'd0, dir_east);
    add_flit(3'd5, 3'd2, 2'd0, dir_east);
    set_table_cmd(cmd_write_rule, 2'd0, {3'd5, 3'd2}, {3'd5, 3'd3}, dir_north);
    add_flit(3'd5, 3'd2, 2'd1, dir_east);
    add_flit(3'd5, 3'd2, 2'd1, dir_east);
    add_flit(3'd5, 3'd5, 2'd1, dir_east);
    add_flit(3'd2, 3'd2, 2'd0, dir_east);
    set_table_cmd(cmd_write_rule, 2'd2, {3'd1, 3'd1}, {3'd1, 3'd1}, dir_eject);
    add_idle();
    add_flit(3'd1, 3'd1, 2'd3, dir_east);
    set_table_cmd(cmd_clear_rule, 2'd0, 6'd0, 6'd0, dir_north);
    add_flit(3'd5, 3'd2, 2'd2, dir_east);
    add_flit(3'd5, 3'd2, 2'd2, dir_east);
    set_table_cmd(cmd_clear_rule, 2'd1, 6'd0, 6'd0, dir_north);
    add_idle();
    add_flit(3'd5, 3'd2, 2'd3, dir_east);
    // random routers, destinations and arrival directions
    for (int k = 0; k < RandRows; k++) begin
      rand_bits(1, v);
      vld = v[0];
      rand_bits(3, v);
      here_x = v[2:0];
      rand_bits(3, v);
      here_y = v[2:0];
      rand_bits(3, v);
      dx = v[2:0];
      rand_bits(3, v);
      dy = v[2:0];
      rand_bits(2, v);
      port = v[1:0];
      rand_bits(3, v);
      push_row(vld, dx, dy, port, v[2:0]);
    end
  endtask

  initial begin
    reset       = 1'b1;
    cur_x       = '0;
    cur_y       = '0;
    in_valid    = 1'b0;
    in_dst_x    = '0;
    in_dst_y    = '0;
    in_dst_port = '0;
    in_la_dir   = '0;
    tbl_cmd     = cmd_nop;
    tbl_idx     = '0;
    tbl_lo      = '0;
    tbl_hi      = '0;
    tbl_dir     = dir_north;
    lfsr        = 32'h39da_55d6;
    m_out       = '0;
    for (int i = 0; i < `NOC_TABLE_DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_lo[i]    = '0;
      m_hi[i]    = '0;
      m_dir[i]   = '0;
    end
    build_stimulus();
    cycle_limit = rows.size() + ResetCycles + Margin;

    // outputs stay cleared through reset
    for (int i = 0; i < ResetCycles; i++) begin
      @(posedge clk);
      if (i == ResetCycles - 1) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      exp_q.push_back(m_out);
      compare_outputs();
    end

    // first cycle out of reset has nothing in flight
    exp_q.push_back(m_out);
    foreach (rows[k]) begin
      @(posedge clk);
      apply_row(rows[k]);
      @(negedge clk);
      compare_outputs();
      model_step(rows[k]);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    tbl_cmd  <= cmd_nop;
    @(negedge clk);
    compare_outputs();

    $display("TEST OK");
    $finish;
  end

endmodule

// File: lookahead_route_stage.sv
/*
 * Look-ahead routing stage at a mesh router input port:
 * XY route at the next hop and id table override side by side,
 * merged and registered with one cycle of latency
 */

`timescale 1ns/1ps

`include "noc_macros.svh"

module lookahead_route_stage
  import route_dir_pkg::*;
  import mesh_coord_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // position of this router in the mesh
  input  x_coord_t               cur_x_i,
  input  y_coord_t               cur_y_i,

  // head flit
  input  logic                   in_valid_i,
  input  x_coord_t               in_dst_x_i,
  input  y_coord_t               in_dst_y_i,
  input  port_id_t               in_dst_port_i,
  input  logic [`NOC_DIR_W-1:0]  in_la_dir_i,

  // table update
  input  table_cmd_e             tbl_cmd_i,
  input  rule_idx_t              tbl_idx_i,
  input  node_id_t               tbl_lo_i,
  input  node_id_t               tbl_hi_i,
  input  route_dir_e             tbl_dir_i,

  output logic                   out_valid_o,
  output x_coord_t               out_dst_x_o,
  output y_coord_t               out_dst_y_o,
  output port_id_t               out_dst_port_o,
  output logic [`NOC_DIR_W-1:0]  out_la_route_o
);

  route_dir_e xy_dir;
  logic       tbl_hit;
  route_dir_e tbl_dir;

  next_hop_xy_route u_next_hop_xy_route (
    .cur_x_i  (cur_x_i),
    .cur_y_i  (cur_y_i),
    .dst_x_i  (in_dst_x_i),
    .dst_y_i  (in_dst_y_i),
    .la_dir_i (in_la_dir_i),
    .xy_dir_o (xy_dir)
  );

  id_table_route u_id_table_route (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd_i   (tbl_cmd_i),
    .idx_i   (tbl_idx_i),
    .lo_i    (tbl_lo_i),
    .hi_i    (tbl_hi_i),
    .dir_i   (tbl_dir_i),
    .dst_x_i (in_dst_x_i),
    .dst_y_i (in_dst_y_i),
    .hit_o   (tbl_hit),
    .dir_o   (tbl_dir)
  );

  route_merge u_route_merge (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (in_valid_i),
    .dst_x_i    (in_dst_x_i),
    .dst_y_i    (in_dst_y_i),
    .dst_port_i (in_dst_port_i),
    .xy_dir_i   (xy_dir),
    .tbl_hit_i  (tbl_hit),
    .tbl_dir_i  (tbl_dir),
    .valid_o    (out_valid_o),
    .dst_x_o    (out_dst_x_o),
    .dst_y_o    (out_dst_y_o),
    .dst_port_o (out_dst_port_o),
    .la_route_o (out_la_route_o)
  );

endmodule

// File: route_merge.sv
/*
 * Route merge and output register:
 * selects the table or XY direction, turns an eject result into an
 * eject index offset by the destination port, and registers the
 * look-ahead route with the header fields
 */

`timescale 1ns/1ps

`include "noc_macros.svh"

module route_merge
  import route_dir_pkg::*;
  import mesh_coord_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   valid_i,
  input  x_coord_t               dst_x_i,
  input  y_coord_t               dst_y_i,
  input  port_id_t               dst_port_i,
  input  route_dir_e             xy_dir_i,
  input  logic                   tbl_hit_i,
  input  route_dir_e             tbl_dir_i,

  output logic                   valid_o,
  output x_coord_t               dst_x_o,
  output y_coord_t               dst_y_o,
  output port_id_t               dst_port_o,
  output logic [`NOC_DIR_W-1:0]  la_route_o
);

  route_dir_e              sel_dir;
  logic [`NOC_DIR_W-1:0]   la_route_d;

  // table entries override plain XY
  assign sel_dir = tbl_hit_i ? tbl_dir_i : xy_dir_i;

  // eject index is eject code plus local port
  always_comb begin
    if (sel_dir >= dir_eject) begin
      la_route_d = sel_dir + `NOC_DIR_W'(dst_port_i);
    end else begin
      la_route_d = sel_dir;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // header and route hold their last value between flits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dst_x_o    <= '0;
      dst_y_o    <= '0;
      dst_port_o <= '0;
      la_route_o <= '0;
    end else if (valid_i) begin
      dst_x_o    <= dst_x_i;
      dst_y_o    <= dst_y_i;
      dst_port_o <= dst_port_i;
      la_route_o <= la_route_d;
    end
  end

endmodule

// File: id_table_route.sv
/*
 * Id range routing table:
 * a small set of writable rules, each an inclusive node id range with
 * a direction, and a combinational lookup that reports the
 * lowest-indexed valid rule containing the destination id
 */

`timescale 1ns/1ps

`include "noc_macros.svh"

module id_table_route
  import route_dir_pkg::*;
  import mesh_coord_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  // rule update
  input  table_cmd_e  cmd_i,
  input  rule_idx_t   idx_i,
  input  node_id_t    lo_i,
  input  node_id_t    hi_i,
  input  route_dir_e  dir_i,

  // lookup
  input  x_coord_t    dst_x_i,
  input  y_coord_t    dst_y_i,
  output logic        hit_o,
  output route_dir_e  dir_o
);

  logic       rule_valid_q [`NOC_TABLE_DEPTH];
  node_id_t   rule_lo_q    [`NOC_TABLE_DEPTH];
  node_id_t   rule_hi_q    [`NOC_TABLE_DEPTH];
  route_dir_e rule_dir_q   [`NOC_TABLE_DEPTH];

  node_id_t   dst_id;

  // valid bits, the only table state cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NOC_TABLE_DEPTH; i++) begin
        rule_valid_q[i] <= 1'b0;
      end
    end else begin
      case (cmd_i)
        cmd_write_rule: rule_valid_q[idx_i] <= 1'b1;
        cmd_clear_rule: rule_valid_q[idx_i] <= 1'b0;
        default: ;
      endcase
    end
  end

  // range and direction of a rule, only meaningful while valid
  always_ff @(posedge clk_i) begin
    if (cmd_i == cmd_write_rule) begin
      rule_lo_q[idx_i]  <= lo_i;
      rule_hi_q[idx_i]  <= hi_i;
      rule_dir_q[idx_i] <= dir_i;
    end
  end

  assign dst_id = {dst_x_i, dst_y_i};

  // walk from the top so the lowest matching index is the one left
  always_comb begin
    hit_o = 1'b0;
    dir_o = dir_north;
    for (int i = `NOC_TABLE_DEPTH - 1; i >= 0; i--) begin
      if (rule_valid_q[i] && (dst_id >= rule_lo_q[i]) && (dst_id <= rule_hi_q[i])) begin
        hit_o = 1'b1;
        dir_o = rule_dir_q[i];
      end
    end
  end

endmodule

// File: next_hop_xy_route.sv
/*
 * Next-hop XY routing:
 * steps the router coordinate one hop along the incoming look-ahead
 * direction and computes the dimension-ordered direction taken at
 * that next router
 */

`timescale 1ns/1ps

`include "noc_macros.svh"

module next_hop_xy_route
  import route_dir_pkg::*;
  import mesh_coord_pkg::*;
(
  input  x_coord_t               cur_x_i,
  input  y_coord_t               cur_y_i,
  input  x_coord_t               dst_x_i,
  input  y_coord_t               dst_y_i,
  input  logic [`NOC_DIR_W-1:0]  la_dir_i,
  output route_dir_e             xy_dir_o
);

  x_coord_t nxt_x;
  y_coord_t nxt_y;

  // coordinate of the router the flit moves to next
  always_comb begin
    nxt_x = cur_x_i;
    nxt_y = cur_y_i;
    case (la_dir_i)
      dir_north: begin
        nxt_y = cur_y_i + 1'b1;
      end
      dir_south: begin
        nxt_y = cur_y_i - 1'b1;
      end
      dir_east: begin
        nxt_x = cur_x_i + 1'b1;
      end
      dir_west: begin
        nxt_x = cur_x_i - 1'b1;
      end
      default: begin
        // eject codes keep the flit at this router
        nxt_x = cur_x_i;
        nxt_y = cur_y_i;
      end
    endcase
  end

  // dimension ordered: resolve x first, then y
  always_comb begin
    if (dst_x_i > nxt_x) begin
      xy_dir_o = dir_east;
    end else if (dst_x_i < nxt_x) begin
      xy_dir_o = dir_west;
    end else if (dst_y_i > nxt_y) begin
      xy_dir_o = dir_north;
    end else if (dst_y_i < nxt_y) begin
      xy_dir_o = dir_south;
    end else begin
      // destination is the next router itself
      xy_dir_o = dir_eject;
    end
  end

endmodule

// File: mesh_coord_pkg.sv
/*
 * Mesh coordinate types:
 * x and y coordinates, packed node id and local port index
 */

`include "noc_macros.svh"

package mesh_coord_pkg;

  typedef logic [`NOC_X_W-1:0] x_coord_t;

  typedef logic [`NOC_Y_W-1:0] y_coord_t;

  // x in the upper bits, y in the lower bits
  typedef logic [`NOC_X_W+`NOC_Y_W-1:0] node_id_t;

  typedef logic [`NOC_PORT_W-1:0] port_id_t;

  // number of bits needed to pick one table rule
  localparam int unsigned RuleIdxW = $clog2(`NOC_TABLE_DEPTH);

  typedef logic [RuleIdxW-1:0] rule_idx_t;

endpackage

// File: route_dir_pkg.sv
/*
 * Routing direction types:
 * route_dir_e, the output direction code of a router
 * table_cmd_e, commands that update the id range table
 */

`include "noc_macros.svh"

package route_dir_pkg;

  // eject codes 5 to 7 are reached by adding the local port to dir_eject
  typedef enum logic [`NOC_DIR_W-1:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_eject = 3'd4
  } route_dir_e;

  typedef enum logic [1:0] {
    cmd_nop        = 2'd0,
    cmd_write_rule = 2'd1,
    cmd_clear_rule = 2'd2
  } table_cmd_e;

endpackage

// File: noc_macros.svh
/*
 * Width and depth defines for the look-ahead routing stage:
 * mesh coordinate widths, local port width, direction code width
 * and the number of rules in the id range table
 */

`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// mesh coordinates, one field per dimension
`define NOC_X_W 3
`define NOC_Y_W 3

// local ports behind each router
`define NOC_PORT_W 2

// direction code, eject plus port must still fit
`define NOC_DIR_W 3

`define NOC_TABLE_DEPTH 4

`endif
